// File: dmem.f
verilog/dmem_pkg.sv
verilog/sram_bank.sv
verilog/lsu_axil_master.sv
verilog/axil_sram_slave.sv
verilog/dmem_top.sv
bench/dmem_assertions.sv
bench/dmem_tb.sv

// File: Bender.yml
package:
  name: dmem

sources:
  - files:
      - verilog/dmem_pkg.sv
      - verilog/sram_bank.sv
      - verilog/lsu_axil_master.sv
      - verilog/axil_sram_slave.sv
      - verilog/dmem_top.sv
  - target: test
    files:
      - bench/dmem_assertions.sv
      - bench/dmem_tb.sv

// File: bench/dmem_tb.sv
// Directed testbench for the data memory path: clock, reset, byte model, tests, compare tasks
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;
  import dmem_pkg::*;

  localparam int TIMEOUT_CYC = 50;
  localparam int N_REGION    = 32;
  localparam int N_RANDOM    = 200;

  logic                   aclk;
  logic                   arst_n;
  logic                   req_valid;
  logic                   req_we;
  logic [DMEM_ADDR_W-1:0] req_addr;
  mem_size_e              req_size;
  logic                   req_signed;
  logic [DMEM_DATA_W-1:0] req_wdata;
  logic                   req_busy;
  logic                   rsp_valid;
  logic [DMEM_DATA_W-1:0] rsp_rdata;
  logic                   rsp_err;

  int          check_count;
  int          error_count;
  int          timeout_count;

  // Expected contents of the window by byte
  logic [7:0] model_mem [DMEM_BYTES];

  always #2 aclk = ~aclk;

  dmem_top dut_i (
    .i_aclk       (aclk),
    .i_arst_n     (arst_n),
    .i_req_valid  (req_valid),
    .i_req_we     (req_we),
    .i_req_addr   (req_addr),
    .i_req_size   (req_size),
    .i_req_signed (req_signed),
    .i_req_wdata  (req_wdata),
    .o_req_busy   (req_busy),
    .o_rsp_valid  (rsp_valid),
    .o_rsp_rdata  (rsp_rdata),
    .o_rsp_err    (rsp_err)
  );

  bind dmem_top dmem_assertions assert_i (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_awvalid   (awvalid),
    .i_awready   (awready),
    .i_awaddr    (awaddr),
    .i_wvalid    (wvalid),
    .i_wready    (wready),
    .i_wdata     (wdata),
    .i_wstrb     (wstrb),
    .i_arvalid   (arvalid),
    .i_arready   (arready),
    .i_araddr    (araddr),
    .i_req_busy  (o_req_busy),
    .i_rsp_valid (o_rsp_valid)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input logic [DMEM_DATA_W-1:0] got,
                            input logic [DMEM_DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_lat(input string name, input integer got, input integer exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic int size_bytes(input mem_size_e size);
    return 1 << int'(size);
  endfunction

  task automatic model_store(input logic [DMEM_ADDR_W-1:0] addr, input mem_size_e size,
                             input logic [DMEM_DATA_W-1:0] data);
    int off;
    off = int'(addr - DMEM_BASE);
    for (int b = 0; b < size_bytes(size); b++) begin
      model_mem[off + b] = data[8*b +: 8];
    end
  endtask

  function automatic logic [DMEM_DATA_W-1:0] model_load(input logic [DMEM_ADDR_W-1:0] addr,
                                                       input mem_size_e size, input logic sgn);
    logic [DMEM_DATA_W-1:0] val;
    int                     off;
    int                     n;
    off = int'(addr - DMEM_BASE);
    n   = size_bytes(size);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val[8*b +: 8] = model_mem[off + b];
    end
    // Fill above the loaded size with its top bit
    if (sgn && val[8*n-1]) begin
      for (int i = 8 * n; i < DMEM_DATA_W; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  function automatic logic [DMEM_ADDR_W-1:0] region_addr(input int k);
    return DMEM_BASE + (k * 16 + 3) * 8;
  endfunction

  // --------------------------------------------------
  // Request driver
  // --------------------------------------------------
  // Latency counts edges from the accepting edge to the one that sees o_rsp_valid
  task automatic do_req(input logic we, input logic [DMEM_ADDR_W-1:0] addr,
                        input mem_size_e size, input logic sgn,
                        input logic [DMEM_DATA_W-1:0] wdata, input bit spam,
                        output logic [DMEM_DATA_W-1:0] rdata, output logic err,
                        output integer lat);
    bit done;
    @(posedge aclk);
    #0.5;
    check_err("o_req_busy before request", req_busy, 1'b0);
    req_valid  = 1'b1;
    req_we     = we;
    req_addr   = addr;
    req_size   = size;
    req_signed = sgn;
    req_wdata  = wdata;
    @(posedge aclk);
    #0.5;
    req_valid = 1'b0;
    lat       = 1;
    done      = 1'b0;
    rdata     = '0;
    err       = 1'b1;
    while (!done && lat <= TIMEOUT_CYC) begin
      // Busy through the response cycle
      check_err("o_req_busy", req_busy, 1'b1);
      if (rsp_valid) begin
        done  = 1'b1;
        rdata = rsp_rdata;
        err   = rsp_err;
      end else begin
        // Extra pulses while busy
        // A taken doubleword store would show up in later loads
        if (spam && ($urandom % 2 == 0)) begin
          req_valid = 1'b1;
          req_we    = $urandom % 2;
          req_addr  = region_addr($urandom % N_REGION);
          req_size  = SIZE_D;
          req_wdata = {$urandom, $urandom};
        end else begin
          req_valid = 1'b0;
        end
        @(posedge aclk);
        #0.5;
        lat++;
      end
    end
    req_valid = 1'b0;
    if (!done) begin
      timeout_count++;
      $display("Timeout: no response within %0d cycles for request to 0x%h",
               TIMEOUT_CYC, addr);
    end
  endtask

  task automatic store_ok(input logic [DMEM_ADDR_W-1:0] addr, input mem_size_e size,
                          input logic [DMEM_DATA_W-1:0] data, input bit spam);
    logic [DMEM_DATA_W-1:0] rdata;
    logic                   err;
    integer                 lat;
    do_req(1'b1, addr, size, 1'b0, data, spam, rdata, err, lat);
    check_err("store o_rsp_err", err, 1'b0);
    check_data("o_rsp_rdata on store", rdata, '0);
    check_lat("store latency", lat, 4);
    model_store(addr, size, data);
  endtask

  task automatic load_check(input logic [DMEM_ADDR_W-1:0] addr, input mem_size_e size,
                            input logic sgn, input bit spam);
    logic [DMEM_DATA_W-1:0] rdata;
    logic                   err;
    integer                 lat;
    do_req(1'b0, addr, size, sgn, '0, spam, rdata, err, lat);
    check_err("load o_rsp_err", err, 1'b0);
    check_lat("load latency", lat, 3);
    check_data("o_rsp_rdata", rdata, model_load(addr, size, sgn));
  endtask

  task automatic req_expect_err(input logic we, input logic [DMEM_ADDR_W-1:0] addr,
                                input mem_size_e size, input integer exp_lat);
    logic [DMEM_DATA_W-1:0] rdata;
    logic                   err;
    integer                 lat;
    do_req(we, addr, size, 1'b1, {2{32'hffff_ffff}}, 1'b0, rdata, err, lat);
    check_err("o_rsp_err", err, 1'b1);
    check_data("o_rsp_rdata on error", rdata, '0);
    check_lat("error latency", lat, exp_lat);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_dword_roundtrip();
    store_ok(DMEM_BASE, SIZE_D, 64'h0123_4567_89ab_cdef, 1'b0);
    load_check(DMEM_BASE, SIZE_D, 1'b0, 1'b0);
  endtask

  task automatic test_subword_merge();
    logic [DMEM_ADDR_W-1:0] a;
    a = DMEM_BASE + 32'h30;
    store_ok(a, SIZE_D, 64'h1122_3344_5566_7788, 1'b0);
    // Upper bytes of the store data must not leak into memory
    store_ok(a + 1, SIZE_B, 64'hdead_beef_cafe_00ab, 1'b0);
    store_ok(a + 2, SIZE_H, 64'hffff_0000_0000_5aa5, 1'b0);
    store_ok(a + 4, SIZE_W, 64'h0bad_f00d_c001_d00d, 1'b0);
    load_check(a, SIZE_D, 1'b0, 1'b0);
  endtask

  task automatic test_extension();
    logic [DMEM_ADDR_W-1:0] a;
    a = DMEM_BASE + 32'h40;
    store_ok(a, SIZE_D, 64'h81e2_53c4_b5a6_1788, 1'b0);
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 8; off++) begin
        load_check(a + off, SIZE_B, s[0], 1'b0);
      end
      for (int off = 0; off < 8; off += 2) begin
        load_check(a + off, SIZE_H, s[0], 1'b0);
      end
      for (int off = 0; off < 8; off += 4) begin
        load_check(a + off, SIZE_W, s[0], 1'b0);
      end
    end
  endtask

  task automatic test_misaligned();
    logic [DMEM_ADDR_W-1:0] a;
    a = DMEM_BASE + 32'h50;
    store_ok(a, SIZE_D, 64'h0f0e_0d0c_0b0a_0908, 1'b0);
    for (int we = 0; we < 2; we++) begin
      req_expect_err(we[0], a + 1, SIZE_H, 1);
      req_expect_err(we[0], a + 2, SIZE_W, 1);
      req_expect_err(we[0], a + 4, SIZE_D, 1);
    end
    load_check(a, SIZE_D, 1'b0, 1'b0);
  endtask

  task automatic test_out_of_window();
    // Last word of the window shares its index with the address just below it
    store_ok(DMEM_BASE + 32'hff8, SIZE_D, 64'h5555_aaaa_3333_cccc, 1'b0);
    req_expect_err(1'b1, DMEM_BASE - 8, SIZE_D, 4);
    req_expect_err(1'b1, DMEM_LIMIT, SIZE_D, 4);
    req_expect_err(1'b0, DMEM_LIMIT + 32'h10, SIZE_D, 3);
    req_expect_err(1'b0, DMEM_BASE - 8, SIZE_D, 3);
    load_check(DMEM_BASE, SIZE_D, 1'b0, 1'b0);
    load_check(DMEM_BASE + 32'hff8, SIZE_D, 1'b0, 1'b0);
  endtask

  task automatic test_random_mix();
    mem_size_e              size;
    logic [DMEM_ADDR_W-1:0] a;
    int                     n;
    for (int k = 0; k < N_REGION; k++) begin
      store_ok(region_addr(k), SIZE_D, {$urandom, $urandom}, 1'b0);
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      size = mem_size_e'($urandom % 4);
      n    = size_bytes(size);
      a    = region_addr($urandom % N_REGION) + (($urandom % 8) & ~(n - 1));
      if ($urandom % 2) begin
        store_ok(a, size, {$urandom, $urandom}, 1'b1);
      end else begin
        load_check(a, size, $urandom % 2, 1'b1);
      end
    end
  endtask

  initial begin
    void'($urandom(28));
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    aclk          = 1'b0;
    arst_n        = 1'b0;
    req_valid     = 1'b0;
    req_we        = 1'b0;
    req_addr      = '0;
    req_size      = SIZE_B;
    req_signed    = 1'b0;
    req_wdata     = '0;
    repeat (8) @(posedge aclk);
    #0.5;
    arst_n = 1'b1;

    test_dword_roundtrip();
    test_subword_merge();
    test_extension();
    test_misaligned();
    test_out_of_window();
    test_random_mix();

    repeat (2) @(posedge aclk);
    $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             check_count, error_count, timeout_count, dut_i.assert_i.fail_count);
    if (error_count == 0 && timeout_count == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/dmem_assertions.sv
// Concurrent AXI-lite and core-side protocol assertions for the data memory top
`timescale 1ns/1ps
`default_nettype none

module dmem_assertions (
  input logic                             i_aclk,
  input logic                             i_arst_n,
  input logic                             i_awvalid,
  input logic                             i_awready,
  input logic [dmem_pkg::DMEM_ADDR_W-1:0] i_awaddr,
  input logic                             i_wvalid,
  input logic                             i_wready,
  input logic [dmem_pkg::DMEM_DATA_W-1:0] i_wdata,
  input logic [dmem_pkg::DMEM_STRB_W-1:0] i_wstrb,
  input logic                             i_arvalid,
  input logic                             i_arready,
  input logic [dmem_pkg::DMEM_ADDR_W-1:0] i_araddr,
  input logic                             i_req_busy,
  input logic                             i_rsp_valid
);
  import dmem_pkg::*;

  int fail_count = 0;

  // --------------------------------------------------
  // Valid held with a stable payload until ready
  // --------------------------------------------------
  aw_stable_a: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_awvalid && !i_awready) |=> (i_awvalid && $stable(i_awaddr)))
    else begin
      $error("AW valid dropped or address changed before ready");
      fail_count++;
    end

  w_stable_a: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_wvalid && !i_wready) |=> (i_wvalid && $stable(i_wdata) && $stable(i_wstrb)))
    else begin
      $error("W valid dropped or payload changed before ready");
      fail_count++;
    end

  ar_stable_a: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)))
    else begin
      $error("AR valid dropped or address changed before ready");
      fail_count++;
    end

  // Core response lasts one cycle
  rsp_pulse_a: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_rsp_valid |=> !i_rsp_valid)
    else begin
      $error("Response valid held for more than one cycle");
      fail_count++;
    end

  reset_idle_a: assert property (@(posedge i_aclk)
    $rose(i_arst_n) |-> (!i_req_busy && !i_rsp_valid))
    else begin
      $error("Busy or response valid high right after reset");
      fail_count++;
    end

  // W is only taken once AW has gone through
  wready_order_a: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    $rose(i_wready) |-> $past(i_awvalid && i_awready))
    else begin
      $error("Write ready rose without a preceding AW transfer");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verilog/dmem_top.sv
// Data memory top: load/store stage, AXI-lite SRAM slave and SRAM bank
`timescale 1ns/1ps
`default_nettype none

module dmem_top (
  input  logic                             i_aclk,
  input  logic                             i_arst_n,
  input  logic                             i_req_valid,
  input  logic                             i_req_we,
  input  logic [dmem_pkg::DMEM_ADDR_W-1:0] i_req_addr,
  input  dmem_pkg::mem_size_e              i_req_size,
  input  logic                             i_req_signed,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_req_wdata,
  output logic                             o_req_busy,
  output logic                             o_rsp_valid,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_rsp_rdata,
  output logic                             o_rsp_err
);
  import dmem_pkg::*;

  // --------------------------------------------------
  // Internal AXI-lite bus
  // --------------------------------------------------
  logic                   awvalid;
  logic                   awready;
  logic [DMEM_ADDR_W-1:0] awaddr;
  logic                   wvalid;
  logic                   wready;
  logic [DMEM_DATA_W-1:0] wdata;
  logic [DMEM_STRB_W-1:0] wstrb;
  logic                   bvalid;
  logic                   bready;
  axi_resp_e              bresp;
  logic                   arvalid;
  logic                   arready;
  logic [DMEM_ADDR_W-1:0] araddr;
  logic                   rvalid;
  logic                   rready;
  logic [DMEM_DATA_W-1:0] rdata;
  axi_resp_e              rresp;

  // SRAM port
  logic                   mem_re;
  logic [DMEM_IDX_W-1:0]  mem_ridx;
  logic [DMEM_DATA_W-1:0] mem_rdata;
  logic                   mem_we;
  logic [DMEM_IDX_W-1:0]  mem_widx;
  logic [DMEM_DATA_W-1:0] mem_wdata;
  logic [DMEM_STRB_W-1:0] mem_wstrb;

  lsu_axil_master lsu_i (
    .i_aclk       (i_aclk),
    .i_arst_n     (i_arst_n),
    .i_req_valid  (i_req_valid),
    .i_req_we     (i_req_we),
    .i_req_addr   (i_req_addr),
    .i_req_size   (i_req_size),
    .i_req_signed (i_req_signed),
    .i_req_wdata  (i_req_wdata),
    .o_req_busy   (o_req_busy),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_rdata  (o_rsp_rdata),
    .o_rsp_err    (o_rsp_err),
    .o_awvalid    (awvalid),
    .o_awaddr     (awaddr),
    .o_wvalid     (wvalid),
    .o_wdata      (wdata),
    .o_wstrb      (wstrb),
    .o_bready     (bready),
    .o_arvalid    (arvalid),
    .o_araddr     (araddr),
    .o_rready     (rready),
    .i_awready    (awready),
    .i_wready     (wready),
    .i_bvalid     (bvalid),
    .i_bresp      (bresp),
    .i_arready    (arready),
    .i_rvalid     (rvalid),
    .i_rdata      (rdata),
    .i_rresp      (rresp)
  );

  axil_sram_slave slave_i (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_awvalid   (awvalid),
    .i_awaddr    (awaddr),
    .i_wvalid    (wvalid),
    .i_wdata     (wdata),
    .i_wstrb     (wstrb),
    .o_awready   (awready),
    .o_wready    (wready),
    .o_bvalid    (bvalid),
    .o_bresp     (bresp),
    .i_bready    (bready),
    .i_arvalid   (arvalid),
    .i_araddr    (araddr),
    .i_rready    (rready),
    .o_arready   (arready),
    .o_rvalid    (rvalid),
    .o_rdata     (rdata),
    .o_rresp     (rresp),
    .o_mem_re    (mem_re),
    .o_mem_ridx  (mem_ridx),
    .o_mem_we    (mem_we),
    .o_mem_widx  (mem_widx),
    .o_mem_wdata (mem_wdata),
    .o_mem_wstrb (mem_wstrb),
    .i_mem_rdata (mem_rdata)
  );

  sram_bank sram_i (
    .i_aclk  (i_aclk),
    .i_re    (mem_re),
    .i_ridx  (mem_ridx),
    .o_rdata (mem_rdata),
    .i_we    (mem_we),
    .i_widx  (mem_widx),
    .i_wdata (mem_wdata),
    .i_wstrb (mem_wstrb)
  );

endmodule

`default_nettype wire

// File: verilog/axil_sram_slave.sv
// AXI-lite SRAM slave: read and write FSMs, address window decode, response codes
`timescale 1ns/1ps
`default_nettype none

module axil_sram_slave (
  input  logic                             i_aclk,
  input  logic                             i_arst_n,
  // Write address and data
  input  logic                             i_awvalid,
  input  logic [dmem_pkg::DMEM_ADDR_W-1:0] i_awaddr,
  input  logic                             i_wvalid,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_wdata,
  input  logic [dmem_pkg::DMEM_STRB_W-1:0] i_wstrb,
  output logic                             o_awready,
  output logic                             o_wready,
  output logic                             o_bvalid,
  output dmem_pkg::axi_resp_e              o_bresp,
  input  logic                             i_bready,
  // Read
  input  logic                             i_arvalid,
  input  logic [dmem_pkg::DMEM_ADDR_W-1:0] i_araddr,
  input  logic                             i_rready,
  output logic                             o_arready,
  output logic                             o_rvalid,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_rdata,
  output dmem_pkg::axi_resp_e              o_rresp,
  // SRAM port
  output logic                             o_mem_re,
  output logic [dmem_pkg::DMEM_IDX_W-1:0]  o_mem_ridx,
  output logic                             o_mem_we,
  output logic [dmem_pkg::DMEM_IDX_W-1:0]  o_mem_widx,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_mem_wdata,
  output logic [dmem_pkg::DMEM_STRB_W-1:0] o_mem_wstrb,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_mem_rdata
);
  import dmem_pkg::*;

  typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

  rd_state_e             rd_state_q;
  wr_state_e             wr_state_q;
  logic                  rd_err_q;
  logic                  aw_ok_q;
  logic [DMEM_IDX_W-1:0] aw_idx_q;
  axi_resp_e             bresp_q;

  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  ar_fire;
  logic                  r_fire;

  function automatic logic in_window(input logic [DMEM_ADDR_W-1:0] addr);
    return (addr >= DMEM_BASE) && (addr < DMEM_LIMIT);
  endfunction

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state_q <= RD_IDLE;
      rd_err_q   <= 1'b0;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            rd_state_q <= RD_DATA;
            rd_err_q   <= !in_window(i_araddr);
          end
        end
        default: if (r_fire) rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // SRAM output holds until the next read, so R can wait on rready
  assign o_mem_re   = ar_fire && in_window(i_araddr);
  assign o_mem_ridx = i_araddr[DMEM_IDX_W+DMEM_OFF_W-1:DMEM_OFF_W];

  assign o_arready  = (rd_state_q == RD_IDLE);
  assign o_rvalid   = (rd_state_q == RD_DATA);
  assign o_rdata    = rd_err_q ? '0 : i_mem_rdata;
  assign o_rresp    = rd_err_q ? RESP_SLVERR : RESP_OKAY;

  // --------------------------------------------------
  // Write channel, AW first then W
  // --------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state_q <= WR_IDLE;
      aw_ok_q    <= 1'b0;
      bresp_q    <= RESP_OKAY;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            wr_state_q <= WR_DATA;
            aw_ok_q    <= in_window(i_awaddr);
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            wr_state_q <= WR_RESP;
            bresp_q    <= aw_ok_q ? RESP_OKAY : RESP_SLVERR;
          end
        end
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // Word index of the captured write address
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_idx_q <= i_awaddr[DMEM_IDX_W+DMEM_OFF_W-1:DMEM_OFF_W];
    end
  end

  // Out-of-window writes are answered but never reach the array
  assign o_mem_we    = w_fire && aw_ok_q;
  assign o_mem_widx  = aw_idx_q;
  assign o_mem_wdata = i_wdata;
  assign o_mem_wstrb = i_wstrb;

  assign o_awready   = (wr_state_q == WR_IDLE);
  assign o_wready    = (wr_state_q == WR_DATA);
  assign o_bvalid    = (wr_state_q == WR_RESP);
  assign o_bresp     = bresp_q;

endmodule

`default_nettype wire

// File: verilog/lsu_axil_master.sv
// Load/store stage: core request strobes to AXI-lite master, load alignment and extension
`timescale 1ns/1ps
`default_nettype none

module lsu_axil_master (
  input  logic                             i_aclk,
  input  logic                             i_arst_n,
  // Core request
  input  logic                             i_req_valid,
  input  logic                             i_req_we,
  input  logic [dmem_pkg::DMEM_ADDR_W-1:0] i_req_addr,
  input  dmem_pkg::mem_size_e              i_req_size,
  input  logic                             i_req_signed,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_req_wdata,
  // Core result
  output logic                             o_req_busy,
  output logic                             o_rsp_valid,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_rsp_rdata,
  output logic                             o_rsp_err,
  // AXI-lite master outputs
  output logic                             o_awvalid,
  output logic [dmem_pkg::DMEM_ADDR_W-1:0] o_awaddr,
  output logic                             o_wvalid,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_wdata,
  output logic [dmem_pkg::DMEM_STRB_W-1:0] o_wstrb,
  output logic                             o_bready,
  output logic                             o_arvalid,
  output logic [dmem_pkg::DMEM_ADDR_W-1:0] o_araddr,
  output logic                             o_rready,
  // AXI-lite master inputs
  input  logic                             i_awready,
  input  logic                             i_wready,
  input  logic                             i_bvalid,
  input  dmem_pkg::axi_resp_e              i_bresp,
  input  logic                             i_arready,
  input  logic                             i_rvalid,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_rdata,
  input  dmem_pkg::axi_resp_e              i_rresp
);
  import dmem_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WR, ST_RD, ST_RSP} state_e;

  state_e                 state_q;
  logic                   awvalid_q;
  logic                   wvalid_q;
  logic                   arvalid_q;
  logic [DMEM_ADDR_W-1:0] addr_q;
  logic [DMEM_OFF_W-1:0]  off_q;
  mem_size_e              size_q;
  logic                   signed_q;
  logic [DMEM_DATA_W-1:0] wdata_q;
  logic [DMEM_STRB_W-1:0] wstrb_q;
  logic [DMEM_DATA_W-1:0] rsp_rdata_q;
  logic                   rsp_err_q;

  logic                   accept;
  logic                   misaligned;
  logic [DMEM_OFF_W-1:0]  req_off;
  logic [DMEM_STRB_W-1:0] strb_base;
  logic [DMEM_DATA_W-1:0] rd_shift;
  logic [DMEM_DATA_W-1:0] rd_ext;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   ar_fire;
  logic                   r_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = i_bvalid & o_bready;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid & o_rready;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  assign req_off = i_req_addr[DMEM_OFF_W-1:0];
  assign accept  = i_req_valid && (state_q == ST_IDLE);

  always_comb begin
    case (i_req_size)
      SIZE_B: begin
        misaligned = 1'b0;
        strb_base  = 8'h01;
      end
      SIZE_H: begin
        misaligned = req_off[0];
        strb_base  = 8'h03;
      end
      SIZE_W: begin
        misaligned = |req_off[1:0];
        strb_base  = 8'h0f;
      end
      default: begin
        misaligned = |req_off;
        strb_base  = 8'hff;
      end
    endcase
  end

  // Loaded bytes down to bit 0, then extend from the top bit of the size
  assign rd_shift = i_rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_B:  rd_ext = {{(DMEM_DATA_W-8){signed_q & rd_shift[7]}}, rd_shift[7:0]};
      SIZE_H:  rd_ext = {{(DMEM_DATA_W-16){signed_q & rd_shift[15]}}, rd_shift[15:0]};
      SIZE_W:  rd_ext = {{(DMEM_DATA_W-32){signed_q & rd_shift[31]}}, rd_shift[31:0]};
      default: rd_ext = rd_shift;
    endcase
  end

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= ST_IDLE;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      if (aw_fire) awvalid_q <= 1'b0;
      if (w_fire) wvalid_q <= 1'b0;
      if (ar_fire) arvalid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            if (misaligned) begin
              // Rejected here, bus stays quiet
              state_q <= ST_RSP;
            end else if (i_req_we) begin
              state_q   <= ST_WR;
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
            end else begin
              state_q   <= ST_RD;
              arvalid_q <= 1'b1;
            end
          end
        end
        ST_WR: if (b_fire) state_q <= ST_RSP;
        ST_RD: if (r_fire) state_q <= ST_RSP;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload and result
  always_ff @(posedge i_aclk) begin
    if (accept) begin
      addr_q      <= {i_req_addr[DMEM_ADDR_W-1:DMEM_OFF_W], {DMEM_OFF_W{1'b0}}};
      off_q       <= req_off;
      size_q      <= i_req_size;
      signed_q    <= i_req_signed;
      wdata_q     <= i_req_wdata << {req_off, 3'b000};
      wstrb_q     <= strb_base << req_off;
      rsp_err_q   <= misaligned;
      rsp_rdata_q <= '0;
    end
    if (b_fire) begin
      rsp_err_q <= (i_bresp != RESP_OKAY);
    end
    if (r_fire) begin
      rsp_err_q   <= (i_rresp != RESP_OKAY);
      rsp_rdata_q <= (i_rresp == RESP_OKAY) ? rd_ext : '0;
    end
  end

  assign o_awvalid   = awvalid_q;
  assign o_awaddr    = addr_q;
  assign o_wvalid    = wvalid_q;
  assign o_wdata     = wdata_q;
  assign o_wstrb     = wstrb_q;
  assign o_bready    = (state_q == ST_WR);
  assign o_arvalid   = arvalid_q;
  assign o_araddr    = addr_q;
  assign o_rready    = (state_q == ST_RD);

  assign o_req_busy  = (state_q != ST_IDLE);
  assign o_rsp_valid = (state_q == ST_RSP);
  assign o_rsp_rdata = rsp_rdata_q;
  assign o_rsp_err   = rsp_err_q;

endmodule

`default_nettype wire

// File: verilog/sram_bank.sv
// Byte-strobed SRAM bank with registered read output
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  logic                             i_aclk,
  input  logic                             i_re,
  input  logic [dmem_pkg::DMEM_IDX_W-1:0]  i_ridx,
  output logic [dmem_pkg::DMEM_DATA_W-1:0] o_rdata,
  input  logic                             i_we,
  input  logic [dmem_pkg::DMEM_IDX_W-1:0]  i_widx,
  input  logic [dmem_pkg::DMEM_DATA_W-1:0] i_wdata,
  input  logic [dmem_pkg::DMEM_STRB_W-1:0] i_wstrb
);
  import dmem_pkg::*;

  logic [DMEM_DATA_W-1:0] mem [DMEM_DEPTH];

  // --------------------------------------------------
  // Write port, one strobe per byte lane
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < DMEM_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_widx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------
  // Output only moves on a read enable
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_ridx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmem_pkg.sv
// Data memory package: bus widths, SRAM geometry, address window, response codes, access sizes
`default_nettype none

package dmem_pkg;

  // --------------------------------------------------
  // Bus and core widths
  // --------------------------------------------------
  localparam int DMEM_ADDR_W = 32;
  localparam int DMEM_DATA_W = 64;
  localparam int DMEM_STRB_W = DMEM_DATA_W / 8;

  // Byte offset within one bus word
  localparam int DMEM_OFF_W  = 3;

  // --------------------------------------------------
  // SRAM geometry and window
  // --------------------------------------------------
  localparam int DMEM_DEPTH  = 512;
  localparam int DMEM_IDX_W  = 9;
  localparam int DMEM_BYTES  = DMEM_DEPTH * DMEM_STRB_W;

  localparam logic [DMEM_ADDR_W-1:0] DMEM_BASE  = 32'h8000_0000;
  // First byte address past the window
  localparam logic [DMEM_ADDR_W-1:0] DMEM_LIMIT = DMEM_BASE + DMEM_BYTES;

  // AXI response codes, only the two used here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // Access size, 1/2/4/8 bytes
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

endpackage

`default_nettype wire
